// File: upscaler.f
video_pkg.sv
vga_sync_pulses.sv
sync_to_blanking.sv
frame_writer.sv
frame_reader.sv
frame_ram_arbiter.sv
upscaler.sv
upscaler_tb.sv

// File: upscaler_tb.sv
`timescale 1ns/1ps
`default_nettype none

module upscaler_tb;

	localparam int COMPONENT_DEPTH = 4;
	localparam int SRC_WIDTH = 8;
	localparam int SRC_HEIGHT = 4;
	localparam int H_FRONT = 2;
	localparam int H_SYNC = 3;
	localparam int H_BACK = 3;
	localparam int V_FRONT = 1;
	localparam int V_SYNC = 2;
	localparam int V_BACK = 1;
	localparam int SRC_PIXELS = SRC_WIDTH * SRC_HEIGHT;
	localparam int WORD_W = 3 * COMPONENT_DEPTH;
	localparam int CLK_PERIOD = 20;
	// Output line and frame length in clocks
	localparam int H_TOTAL = 2 * SRC_WIDTH + H_FRONT + H_SYNC + H_BACK;
	localparam int V_TOTAL = 2 * SRC_HEIGHT + V_FRONT + V_SYNC + V_BACK;
	localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
	// Slowest input frame with three-cycle gaps and sync pulses
	localparam int LOAD_CYCLES = 3 * SRC_PIXELS + 2 * SRC_HEIGHT + 4;
	localparam int WATCHDOG_NS = (4 * FRAME_CYCLES + 2 * LOAD_CYCLES) * CLK_PERIOD;

	logic i_clk;
	logic i_reset;
	logic i_pix_en;
	logic [COMPONENT_DEPTH-1:0] i_red;
	logic [COMPONENT_DEPTH-1:0] i_green;
	logic [COMPONENT_DEPTH-1:0] i_blue;
	logic i_hsync;
	logic i_vsync;
	logic [COMPONENT_DEPTH-1:0] o_red;
	logic [COMPONENT_DEPTH-1:0] o_green;
	logic [COMPONENT_DEPTH-1:0] o_blue;
	logic o_hsync;
	logic o_vsync;
	logic o_hblank;
	logic o_vblank;

	// Source frames as {red, green, blue} in row order
	logic [WORD_W-1:0] frame_a [SRC_PIXELS];
	logic [WORD_W-1:0] frame_b [SRC_PIXELS];

	// Monitor state
	logic monitor_on;
	bit sync_prev [2];
	bit sync_seen [2];
	int sync_period [2];
	int sync_high [2];
	bit hblank_prev = 1'b1;
	bit vblank_prev = 1'b1;
	bit hblank_seen;
	bit vblank_seen;
	int hblank_run;
	int line_count;

	upscaler #(
		.COMPONENT_DEPTH(COMPONENT_DEPTH),
		.SRC_WIDTH(SRC_WIDTH),
		.SRC_HEIGHT(SRC_HEIGHT),
		.H_FRONT(H_FRONT),
		.H_SYNC(H_SYNC),
		.H_BACK(H_BACK),
		.V_FRONT(V_FRONT),
		.V_SYNC(V_SYNC),
		.V_BACK(V_BACK)
	) dut_i (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_pix_en(i_pix_en),
		.i_red(i_red),
		.i_green(i_green),
		.i_blue(i_blue),
		.i_hsync(i_hsync),
		.i_vsync(i_vsync),
		.o_red(o_red),
		.o_green(o_green),
		.o_blue(o_blue),
		.o_hsync(o_hsync),
		.o_vsync(o_vsync),
		.o_hblank(o_hblank),
		.o_vblank(o_vblank)
	);

	initial begin
		i_clk = 1'b0;
		forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
	end

	////////////////////////////////////////
	// Error reporting and compare tasks
	////////////////////////////////////////

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("Simulation finished: FAIL");
		$fatal(1, "Stopped at first error");
	endtask

	task automatic check_color(input string name, input logic [COMPONENT_DEPTH-1:0] expected,
		input logic [COMPONENT_DEPTH-1:0] observed);
		if (observed !== expected) begin
			report_failure($sformatf("Fail at %0d ns: %s expected %0h observed %0h",
				$time, name, expected, observed));
		end
	endtask

	task automatic check_level(input string name, input logic expected, input logic observed);
		if (observed !== expected) begin
			report_failure($sformatf("Fail at %0d ns: %s expected %b observed %b",
				$time, name, expected, observed));
		end
	endtask

	task automatic check_count(input string name, input int expected, input int observed);
		if (observed != expected) begin
			report_failure($sformatf("Fail at %0d ns: %s expected %0d observed %0d",
				$time, name, expected, observed));
		end
	endtask

	task automatic check_idle_outputs();
		check_level("o_hsync", 1'b0, o_hsync);
		check_level("o_vsync", 1'b0, o_vsync);
		check_level("o_hblank", 1'b1, o_hblank);
		check_level("o_vblank", 1'b1, o_vblank);
		check_color("o_red", '0, o_red);
		check_color("o_green", '0, o_green);
		check_color("o_blue", '0, o_blue);
	endtask

	function automatic logic [WORD_W-1:0] source_word(input int tbl, input int idx);
		if (tbl == 0) begin
			return frame_a[idx];
		end
		return frame_b[idx];
	endfunction

	////////////////////////////////////////
	// Sync and blank monitors
	////////////////////////////////////////

	// Period between rising edges and pulse width in clocks
	task automatic track_sync(input int idx, input logic level, input string name,
		input int period, input int width);
		if (level && !sync_prev[idx]) begin
			if (sync_seen[idx]) begin
				check_count({name, " period"}, period, sync_period[idx]);
			end
			sync_seen[idx] = 1'b1;
			sync_period[idx] = 1;
			sync_high[idx] = 1;
		end else begin
			sync_period[idx]++;
			if (level) begin
				sync_high[idx]++;
			end else if (sync_prev[idx] && sync_seen[idx]) begin
				check_count({name, " width"}, width, sync_high[idx]);
			end
		end
		sync_prev[idx] = level;
	endtask

	always @(negedge i_clk) begin
		if (monitor_on) begin
			track_sync(0, o_hsync, "o_hsync", H_TOTAL, H_SYNC);
			track_sync(1, o_vsync, "o_vsync", FRAME_CYCLES, V_SYNC * H_TOTAL);
			// Vertical blank falls together with the first hblank fall
			if (!o_vblank && vblank_prev) begin
				vblank_seen = 1'b1;
				line_count = 0;
			end
			if (!o_hblank && hblank_prev) begin
				hblank_seen = 1'b1;
				hblank_run = 0;
				if (!o_vblank) begin
					line_count++;
				end
			end
			if (!o_hblank) begin
				hblank_run++;
			end
			if (o_hblank && !hblank_prev && hblank_seen) begin
				check_count("hblank low cycles", 2 * SRC_WIDTH, hblank_run);
			end
			if (o_vblank && !vblank_prev && vblank_seen) begin
				check_count("active lines", 2 * SRC_HEIGHT, line_count);
			end
			// No color may leak into blanking
			if (o_hblank || o_vblank) begin
				check_color("o_red in blank", '0, o_red);
				check_color("o_green in blank", '0, o_green);
				check_color("o_blue in blank", '0, o_blue);
			end
			hblank_prev = o_hblank;
			vblank_prev = o_vblank;
		end
	end

	initial begin
		#(WATCHDOG_NS);
		report_failure("Timeout: the output frames did not arrive in the expected time");
	end

	////////////////////////////////////////
	// Stimulus and frame checks
	////////////////////////////////////////

	// One input frame with vsync first and hsync after every row
	task automatic load_frame(input int tbl, input bit random_gaps);
		logic [WORD_W-1:0] word;
		int gap;
		int row;
		int col;
		@(posedge i_clk);
		i_vsync <= 1'b1;
		@(posedge i_clk);
		i_vsync <= 1'b0;
		for (row = 0; row < SRC_HEIGHT; row++) begin
			for (col = 0; col < SRC_WIDTH; col++) begin
				word = source_word(tbl, row * SRC_WIDTH + col);
				gap = random_gaps ? 2 + int'($urandom % 2) : 2;
				@(posedge i_clk);
				i_pix_en <= 1'b1;
				i_red <= word[WORD_W-1 -: COMPONENT_DEPTH];
				i_green <= word[2*COMPONENT_DEPTH-1 -: COMPONENT_DEPTH];
				i_blue <= word[COMPONENT_DEPTH-1:0];
				@(posedge i_clk);
				i_pix_en <= 1'b0;
				repeat (gap - 2) @(posedge i_clk);
			end
			@(posedge i_clk);
			i_hsync <= 1'b1;
			@(posedge i_clk);
			i_hsync <= 1'b0;
		end
	endtask

	task automatic wait_vsync_rise();
		@(negedge i_clk);
		while (o_vsync !== 1'b0) @(negedge i_clk);
		while (o_vsync !== 1'b1) @(negedge i_clk);
	endtask

	task automatic wait_vblank_fall();
		@(negedge i_clk);
		while (o_vblank !== 1'b1) @(negedge i_clk);
		while (o_vblank !== 1'b0) @(negedge i_clk);
	endtask

	// Pixel (x, y) of the next frame shows source (x/2, y/2)
	task automatic check_frame(input int tbl);
		logic [WORD_W-1:0] word;
		logic now_active;
		logic prev_active;
		int x;
		int y;
		x = 0;
		y = 0;
		prev_active = 1'b0;
		wait_vsync_rise();
		while (y < 2 * SRC_HEIGHT) begin
			@(negedge i_clk);
			now_active = !o_hblank && !o_vblank;
			if (now_active) begin
				word = source_word(tbl, (y / 2) * SRC_WIDTH + x / 2);
				check_color("o_red", word[WORD_W-1 -: COMPONENT_DEPTH], o_red);
				check_color("o_green", word[2*COMPONENT_DEPTH-1 -: COMPONENT_DEPTH], o_green);
				check_color("o_blue", word[COMPONENT_DEPTH-1:0], o_blue);
				x++;
			end else if (prev_active) begin
				check_count("pixels in output line", 2 * SRC_WIDTH, x);
				x = 0;
				y++;
			end
			prev_active = now_active;
		end
	endtask

	initial begin
		frame_a = '{12'h1A2, 12'h2B3, 12'h3C4, 12'h4D5, 12'h5E6, 12'h6F7, 12'h708, 12'h819,
			12'h92A, 12'hA3B, 12'hB4C, 12'hC5D, 12'hD6E, 12'hE7F, 12'hF80, 12'h091,
			12'h123, 12'h234, 12'h345, 12'h456, 12'h567, 12'h678, 12'h789, 12'h89A,
			12'h9AB, 12'hABC, 12'hBCD, 12'hCDE, 12'hDEF, 12'hEF0, 12'hF01, 12'h012};
		frame_b = '{12'hF0F, 12'h0F0, 12'hE1E, 12'h1E1, 12'hD2D, 12'h2D2, 12'hC3C, 12'h3C3,
			12'hB4B, 12'h4B4, 12'hA5A, 12'h5A5, 12'h969, 12'h696, 12'h878, 12'h787,
			12'h3F1, 12'h4E2, 12'h5D3, 12'h6C4, 12'h7B5, 12'h8A6, 12'h997, 12'hA88,
			12'hB79, 12'hC6A, 12'hD5B, 12'hE4C, 12'hF3D, 12'h02E, 12'h11F, 12'h200};
		void'($urandom(39));
		i_reset = 1'b1;
		i_pix_en = 1'b0;
		i_red = '0;
		i_green = '0;
		i_blue = '0;
		i_hsync = 1'b0;
		i_vsync = 1'b0;
		monitor_on = 1'b0;
		// Outputs idle while reset is held
		repeat (3) @(posedge i_clk);
		@(negedge i_clk);
		check_idle_outputs();
		@(posedge i_clk);
		i_reset <= 1'b0;
		monitor_on <= 1'b1;
		// Still idle in the first cycle out of reset
		@(posedge i_clk);
		@(negedge i_clk);
		check_idle_outputs();
		// First frame loaded while output is still blank
		load_frame(0, 1'b0);
		check_frame(0);
		// Second frame written against reader priority
		wait_vblank_fall();
		load_frame(1, 1'b1);
		check_frame(1);
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// File: upscaler.sv
`timescale 1ns/1ps
`default_nettype none

module upscaler #(
	parameter int COMPONENT_DEPTH = 4,
	parameter int SRC_WIDTH = 8,
	parameter int SRC_HEIGHT = 4,
	parameter int H_FRONT = 2,
	parameter int H_SYNC = 3,
	parameter int H_BACK = 3,
	parameter int V_FRONT = 1,
	parameter int V_SYNC = 2,
	parameter int V_BACK = 1
) (
	input wire i_clk,
	input wire i_reset,
	input wire i_pix_en,
	input wire [COMPONENT_DEPTH-1:0] i_red,
	input wire [COMPONENT_DEPTH-1:0] i_green,
	input wire [COMPONENT_DEPTH-1:0] i_blue,
	input wire i_hsync,
	input wire i_vsync,
	output logic [COMPONENT_DEPTH-1:0] o_red,
	output logic [COMPONENT_DEPTH-1:0] o_green,
	output logic [COMPONENT_DEPTH-1:0] o_blue,
	output logic o_hsync,
	output logic o_vsync,
	output logic o_hblank,
	output logic o_vblank
);

	// 2x output area
	localparam int ACTIVE_WIDTH = 2 * SRC_WIDTH;
	localparam int ACTIVE_HEIGHT = 2 * SRC_HEIGHT;
	localparam int ADDR_W = $clog2(SRC_WIDTH * SRC_HEIGHT);
	localparam int WORD_W = 3 * COMPONENT_DEPTH;

	logic gen_hsync;
	logic gen_vsync;
	logic blk_hsync;
	logic blk_vsync;
	logic blk_hblank;
	logic blk_vblank;
	logic rd_req;
	logic [ADDR_W-1:0] rd_addr;
	logic [WORD_W-1:0] rd_data;
	logic wr_req;
	logic [ADDR_W-1:0] wr_addr;
	logic [WORD_W-1:0] wr_data;
	video_pkg::grant_e grant;

	////////////////////////////////////////
	// Output timing
	////////////////////////////////////////

	vga_sync_pulses #(
		.ACTIVE_WIDTH(ACTIVE_WIDTH),
		.ACTIVE_HEIGHT(ACTIVE_HEIGHT),
		.H_FRONT(H_FRONT),
		.H_SYNC(H_SYNC),
		.H_BACK(H_BACK),
		.V_FRONT(V_FRONT),
		.V_SYNC(V_SYNC),
		.V_BACK(V_BACK)
	) sync_gen_i (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.o_hsync(gen_hsync),
		.o_vsync(gen_vsync)
	);

	sync_to_blanking #(
		.ACTIVE_WIDTH(ACTIVE_WIDTH),
		.ACTIVE_HEIGHT(ACTIVE_HEIGHT),
		.H_FRONT(H_FRONT),
		.H_SYNC(H_SYNC),
		.H_BACK(H_BACK),
		.V_FRONT(V_FRONT),
		.V_SYNC(V_SYNC),
		.V_BACK(V_BACK)
	) blanking_i (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_hsync(gen_hsync),
		.i_vsync(gen_vsync),
		.o_hsync(blk_hsync),
		.o_vsync(blk_vsync),
		.o_hblank(blk_hblank),
		.o_vblank(blk_vblank)
	);

	////////////////////////////////////////
	// Frame memory peers
	////////////////////////////////////////

	frame_writer #(
		.COMPONENT_DEPTH(COMPONENT_DEPTH),
		.SRC_WIDTH(SRC_WIDTH),
		.SRC_HEIGHT(SRC_HEIGHT)
	) writer_i (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_pix_en(i_pix_en),
		.i_red(i_red),
		.i_green(i_green),
		.i_blue(i_blue),
		.i_hsync(i_hsync),
		.i_vsync(i_vsync),
		.i_grant(grant),
		.o_wr_req(wr_req),
		.o_wr_addr(wr_addr),
		.o_wr_data(wr_data)
	);

	frame_reader #(
		.COMPONENT_DEPTH(COMPONENT_DEPTH),
		.SRC_WIDTH(SRC_WIDTH),
		.SRC_HEIGHT(SRC_HEIGHT)
	) reader_i (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_hsync(blk_hsync),
		.i_vsync(blk_vsync),
		.i_hblank(blk_hblank),
		.i_vblank(blk_vblank),
		.i_grant(grant),
		.i_rd_data(rd_data),
		.o_rd_req(rd_req),
		.o_rd_addr(rd_addr),
		.o_red(o_red),
		.o_green(o_green),
		.o_blue(o_blue),
		.o_hsync(o_hsync),
		.o_vsync(o_vsync),
		.o_hblank(o_hblank),
		.o_vblank(o_vblank)
	);

	// Reader wins every contended cycle
	frame_ram_arbiter #(
		.COMPONENT_DEPTH(COMPONENT_DEPTH),
		.SRC_WIDTH(SRC_WIDTH),
		.SRC_HEIGHT(SRC_HEIGHT)
	) arbiter_i (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_rd_req(rd_req),
		.i_rd_addr(rd_addr),
		.i_wr_req(wr_req),
		.i_wr_addr(wr_addr),
		.i_wr_data(wr_data),
		.o_grant(grant),
		.o_rd_data(rd_data)
	);

endmodule

`default_nettype wire

// File: frame_ram_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module frame_ram_arbiter #(
	parameter int COMPONENT_DEPTH = 4,
	parameter int SRC_WIDTH = 8,
	parameter int SRC_HEIGHT = 4
) (
	input wire i_clk,
	input wire i_reset,
	input wire i_rd_req,
	input wire [$clog2(SRC_WIDTH*SRC_HEIGHT)-1:0] i_rd_addr,
	input wire i_wr_req,
	input wire [$clog2(SRC_WIDTH*SRC_HEIGHT)-1:0] i_wr_addr,
	input wire [3*COMPONENT_DEPTH-1:0] i_wr_data,
	output video_pkg::grant_e o_grant,
	output logic [3*COMPONENT_DEPTH-1:0] o_rd_data
);

	localparam int DEPTH = SRC_WIDTH * SRC_HEIGHT;
	localparam int ADDR_W = $clog2(DEPTH);
	localparam int WORD_W = 3 * COMPONENT_DEPTH;

	logic [WORD_W-1:0] mem [DEPTH];
	logic [ADDR_W-1:0] port_addr;
	logic [WORD_W-1:0] port_q;

	////////////////////////////////////////
	// Fixed priority with the reader first
	////////////////////////////////////////

	always_comb begin
		if (i_rd_req) begin
			o_grant = video_pkg::GRANT_READER;
		end else if (i_wr_req) begin
			o_grant = video_pkg::GRANT_WRITER;
		end else begin
			o_grant = video_pkg::GRANT_IDLE;
		end
	end

	// Single port address mux
	assign port_addr = (o_grant == video_pkg::GRANT_READER) ? i_rd_addr : i_wr_addr;
	assign port_q = mem[port_addr];

	always_ff @(posedge i_clk) begin
		if (o_grant == video_pkg::GRANT_WRITER) begin
			mem[port_addr] <= i_wr_data;
		end
	end

	// Port word registered each cycle and valid the cycle after a reader grant
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			o_rd_data <= '0;
		end else begin
			o_rd_data <= port_q;
		end
	end

endmodule

`default_nettype wire

// File: frame_reader.sv
`timescale 1ns/1ps
`default_nettype none

module frame_reader #(
	parameter int COMPONENT_DEPTH = 4,
	parameter int SRC_WIDTH = 8,
	parameter int SRC_HEIGHT = 4
) (
	input wire i_clk,
	input wire i_reset,
	input wire i_hsync,
	input wire i_vsync,
	input wire i_hblank,
	input wire i_vblank,
	input wire video_pkg::grant_e i_grant,
	input wire [3*COMPONENT_DEPTH-1:0] i_rd_data,
	output logic o_rd_req,
	output logic [$clog2(SRC_WIDTH*SRC_HEIGHT)-1:0] o_rd_addr,
	output logic [COMPONENT_DEPTH-1:0] o_red,
	output logic [COMPONENT_DEPTH-1:0] o_green,
	output logic [COMPONENT_DEPTH-1:0] o_blue,
	output logic o_hsync,
	output logic o_vsync,
	output logic o_hblank,
	output logic o_vblank
);

	localparam int ADDR_W = $clog2(SRC_WIDTH * SRC_HEIGHT);
	localparam int WORD_W = 3 * COMPONENT_DEPTH;
	// Output area is twice the source; row reaches the full count
	localparam int COL_W = $clog2(2 * SRC_WIDTH) + 1;
	localparam int ROW_W = $clog2(2 * SRC_HEIGHT) + 1;

	logic active;
	logic active_q;
	logic [COL_W-1:0] col;
	logic [ROW_W-1:0] row;
	logic rd_fresh;
	logic [WORD_W-1:0] pix_word;
	logic [WORD_W-1:0] cur_word;
	logic [1:0] hsync_pipe;
	logic [1:0] vsync_pipe;
	logic [1:0] hblank_pipe;
	logic [1:0] vblank_pipe;

	assign active = !i_hblank && !i_vblank;

	////////////////////////////////////////
	// Stage 0, scan position and request
	////////////////////////////////////////

	// One read per pair of output pixels
	assign o_rd_req = active && !col[0];
	assign o_rd_addr = ADDR_W'((row >> 1) * SRC_WIDTH + (col >> 1));

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			col <= '0;
			row <= '0;
			active_q <= 1'b0;
			rd_fresh <= 1'b0;
		end else begin
			active_q <= active;
			rd_fresh <= (i_grant == video_pkg::GRANT_READER);
			col <= active ? col + 1'b1 : '0;
			// Line count bumps as each active line ends
			if (i_vblank) begin
				row <= '0;
			end else if (active_q && !active) begin
				row <= row + 1'b1;
			end
		end
	end

	////////////////////////////////////////
	// Stage 1, word hold and color out
	////////////////////////////////////////

	// Fresh word on even pixels, held copy on odd ones
	assign cur_word = rd_fresh ? i_rd_data : pix_word;

	always_ff @(posedge i_clk) begin
		if (rd_fresh) begin
			pix_word <= i_rd_data;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			o_red <= '0;
			o_green <= '0;
			o_blue <= '0;
		end else begin
			o_red <= active_q ? cur_word[WORD_W-1 -: COMPONENT_DEPTH] : '0;
			o_green <= active_q ? cur_word[2*COMPONENT_DEPTH-1 -: COMPONENT_DEPTH] : '0;
			o_blue <= active_q ? cur_word[COMPONENT_DEPTH-1:0] : '0;
		end
	end

	// Timing delayed two cycles to match colors
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			hsync_pipe <= 2'b00;
			vsync_pipe <= 2'b00;
			hblank_pipe <= 2'b11;
			vblank_pipe <= 2'b11;
		end else begin
			hsync_pipe <= {hsync_pipe[0], i_hsync};
			vsync_pipe <= {vsync_pipe[0], i_vsync};
			hblank_pipe <= {hblank_pipe[0], i_hblank};
			vblank_pipe <= {vblank_pipe[0], i_vblank};
		end
	end

	assign o_hsync = hsync_pipe[1];
	assign o_vsync = vsync_pipe[1];
	assign o_hblank = hblank_pipe[1];
	assign o_vblank = vblank_pipe[1];

endmodule

`default_nettype wire

// File: frame_writer.sv
`timescale 1ns/1ps
`default_nettype none

module frame_writer #(
	parameter int COMPONENT_DEPTH = 4,
	parameter int SRC_WIDTH = 8,
	parameter int SRC_HEIGHT = 4
) (
	input wire i_clk,
	input wire i_reset,
	input wire i_pix_en,
	input wire [COMPONENT_DEPTH-1:0] i_red,
	input wire [COMPONENT_DEPTH-1:0] i_green,
	input wire [COMPONENT_DEPTH-1:0] i_blue,
	input wire i_hsync,
	input wire i_vsync,
	input wire video_pkg::grant_e i_grant,
	output logic o_wr_req,
	output logic [$clog2(SRC_WIDTH*SRC_HEIGHT)-1:0] o_wr_addr,
	output logic [3*COMPONENT_DEPTH-1:0] o_wr_data
);

	localparam int ADDR_W = $clog2(SRC_WIDTH * SRC_HEIGHT);
	// Column runs one past the last pixel before hsync
	localparam int COL_W = $clog2(SRC_WIDTH + 1);
	localparam int ROW_W = $clog2(SRC_HEIGHT + 1);

	logic [COL_W-1:0] col;
	logic [ROW_W-1:0] row;

	////////////////////////////////////////
	// Source position tracking
	////////////////////////////////////////

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			col <= '0;
			row <= '0;
		end else if (i_vsync) begin
			// New frame
			col <= '0;
			row <= '0;
		end else if (i_hsync) begin
			col <= '0;
			row <= row + 1'b1;
		end else if (i_pix_en) begin
			col <= col + 1'b1;
		end
	end

	// Pending request, cleared once the arbiter grants it
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			o_wr_req <= 1'b0;
		end else if (i_pix_en) begin
			o_wr_req <= 1'b1;
		end else if (i_grant == video_pkg::GRANT_WRITER) begin
			o_wr_req <= 1'b0;
		end
	end

	// Pending word and its address
	always_ff @(posedge i_clk) begin
		if (i_pix_en) begin
			o_wr_data <= {i_red, i_green, i_blue};
			o_wr_addr <= ADDR_W'(row * SRC_WIDTH + col);
		end
	end

endmodule

`default_nettype wire

// File: sync_to_blanking.sv
`timescale 1ns/1ps
`default_nettype none

module sync_to_blanking #(
	parameter int ACTIVE_WIDTH = 16,
	parameter int ACTIVE_HEIGHT = 8,
	parameter int H_FRONT = 2,
	parameter int H_SYNC = 3,
	parameter int H_BACK = 3,
	parameter int V_FRONT = 1,
	parameter int V_SYNC = 2,
	parameter int V_BACK = 1
) (
	input wire i_clk,
	input wire i_reset,
	input wire i_hsync,
	input wire i_vsync,
	output logic o_hsync,
	output logic o_vsync,
	output logic o_hblank,
	output logic o_vblank
);

	localparam int H_CNT_W = $clog2(ACTIVE_WIDTH + H_FRONT + H_SYNC + H_BACK);
	localparam int V_CNT_W = $clog2(ACTIVE_HEIGHT + V_FRONT + V_SYNC + V_BACK);

	video_pkg::timing_phase_e h_phase;
	video_pkg::timing_phase_e v_phase;
	logic [H_CNT_W-1:0] h_cnt;
	logic [V_CNT_W-1:0] v_cnt;
	logic [H_CNT_W-1:0] h_last;
	logic [V_CNT_W-1:0] v_last;
	logic hsync_d;
	logic vsync_d;
	logic hsync_rise;
	logic vsync_rise;
	logic line_end;

	// Sync edges restart the counters
	assign hsync_rise = i_hsync && !hsync_d;
	assign vsync_rise = i_vsync && !vsync_d;

	assign h_last = H_CNT_W'(video_pkg::phase_length(h_phase, ACTIVE_WIDTH,
		H_FRONT, H_SYNC, H_BACK) - 1);
	assign v_last = V_CNT_W'(video_pkg::phase_length(v_phase, ACTIVE_HEIGHT,
		V_FRONT, V_SYNC, V_BACK) - 1);

	// Own line boundary, end of back porch
	assign line_end = (h_phase == video_pkg::PHASE_BACK) && (h_cnt == h_last)
		&& !hsync_rise;

	// Blank outside active phase
	assign o_hblank = (h_phase != video_pkg::PHASE_ACTIVE);
	assign o_vblank = (v_phase != video_pkg::PHASE_ACTIVE);

	////////////////////////////////////////
	// Edge-started phase counters
	////////////////////////////////////////

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			// Front porch holds until the first edge
			h_phase <= video_pkg::PHASE_FRONT;
			h_cnt <= '0;
			v_phase <= video_pkg::PHASE_FRONT;
			v_cnt <= '0;
			hsync_d <= 1'b0;
			vsync_d <= 1'b0;
			o_hsync <= 1'b0;
			o_vsync <= 1'b0;
		end else begin
			hsync_d <= i_hsync;
			vsync_d <= i_vsync;
			// Syncs re-timed to line up with phase registers
			o_hsync <= i_hsync;
			o_vsync <= i_vsync;

			if (hsync_rise) begin
				h_phase <= video_pkg::PHASE_SYNC;
				h_cnt <= '0;
			end else if (h_cnt != h_last) begin
				h_cnt <= h_cnt + 1'b1;
			end else if (h_phase != video_pkg::PHASE_FRONT) begin
				h_cnt <= '0;
				h_phase <= video_pkg::next_phase(h_phase);
			end

			// Vertical edge wins over a coincident line end
			if (vsync_rise) begin
				v_phase <= video_pkg::PHASE_SYNC;
				v_cnt <= '0;
			end else if (line_end) begin
				if (v_cnt != v_last) begin
					v_cnt <= v_cnt + 1'b1;
				end else if (v_phase != video_pkg::PHASE_FRONT) begin
					v_cnt <= '0;
					v_phase <= video_pkg::next_phase(v_phase);
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: vga_sync_pulses.sv
`timescale 1ns/1ps
`default_nettype none

module vga_sync_pulses #(
	parameter int ACTIVE_WIDTH = 16,
	parameter int ACTIVE_HEIGHT = 8,
	parameter int H_FRONT = 2,
	parameter int H_SYNC = 3,
	parameter int H_BACK = 3,
	parameter int V_FRONT = 1,
	parameter int V_SYNC = 2,
	parameter int V_BACK = 1
) (
	input wire i_clk,
	input wire i_reset,
	output logic o_hsync,
	output logic o_vsync
);

	// Counters wide enough for a whole line or frame
	localparam int H_CNT_W = $clog2(ACTIVE_WIDTH + H_FRONT + H_SYNC + H_BACK);
	localparam int V_CNT_W = $clog2(ACTIVE_HEIGHT + V_FRONT + V_SYNC + V_BACK);

	video_pkg::timing_phase_e h_phase;
	video_pkg::timing_phase_e v_phase;
	logic [H_CNT_W-1:0] h_cnt;
	logic [V_CNT_W-1:0] v_cnt;
	logic [H_CNT_W-1:0] h_last;
	logic [V_CNT_W-1:0] v_last;
	logic line_end;

	// Last count of the current phase
	assign h_last = H_CNT_W'(video_pkg::phase_length(h_phase, ACTIVE_WIDTH,
		H_FRONT, H_SYNC, H_BACK) - 1);
	assign v_last = V_CNT_W'(video_pkg::phase_length(v_phase, ACTIVE_HEIGHT,
		V_FRONT, V_SYNC, V_BACK) - 1);

	// Line boundary sits at the end of the back porch
	assign line_end = (h_phase == video_pkg::PHASE_BACK) && (h_cnt == h_last);

	////////////////////////////////////////
	// Pixel and line counters
	////////////////////////////////////////

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			// Start of back porch, both syncs low
			h_phase <= video_pkg::PHASE_BACK;
			h_cnt <= '0;
			v_phase <= video_pkg::PHASE_BACK;
			v_cnt <= '0;
			o_hsync <= 1'b0;
			o_vsync <= 1'b0;
		end else begin
			if (h_cnt == h_last) begin
				h_cnt <= '0;
				h_phase <= video_pkg::next_phase(h_phase);
			end else begin
				h_cnt <= h_cnt + 1'b1;
			end
			// Vertical steps once per line
			if (line_end) begin
				if (v_cnt == v_last) begin
					v_cnt <= '0;
					v_phase <= video_pkg::next_phase(v_phase);
				end else begin
					v_cnt <= v_cnt + 1'b1;
				end
			end
			// Registered sync pulses
			o_hsync <= (h_phase == video_pkg::PHASE_SYNC);
			o_vsync <= (v_phase == video_pkg::PHASE_SYNC);
		end
	end

endmodule

`default_nettype wire

// File: video_pkg.sv
`default_nettype none

package video_pkg;

	// Owner of the frame memory port in the current cycle
	typedef enum logic [1:0] {
		GRANT_IDLE,
		GRANT_WRITER,
		GRANT_READER
	} grant_e;

	// Horizontal and vertical counter states
	typedef enum logic [1:0] {
		PHASE_ACTIVE,
		PHASE_FRONT,
		PHASE_SYNC,
		PHASE_BACK
	} timing_phase_e;

	// Length of a phase in pixels or lines
	function automatic int phase_length(timing_phase_e phase, int active, int front,
		int sync, int back);
		case (phase)
			PHASE_ACTIVE: return active;
			PHASE_FRONT: return front;
			PHASE_SYNC: return sync;
			default: return back;
		endcase
	endfunction

	// Phase order: active, front porch, sync, back porch
	function automatic timing_phase_e next_phase(timing_phase_e phase);
		case (phase)
			PHASE_ACTIVE: return PHASE_FRONT;
			PHASE_FRONT: return PHASE_SYNC;
			PHASE_SYNC: return PHASE_BACK;
			default: return PHASE_ACTIVE;
		endcase
	endfunction

endpackage

`default_nettype wire
